//--- filelist.f
rtl/masterPkg.sv
rtl/arbiterRequester.sv
rtl/serialShifter.sv
rtl/readCollector.sv
rtl/masterSequencer.sv
rtl/masterExternal.sv
dv/busModel.sv
dv/masterTb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := masterTb
FILELIST := filelist.f
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q '>>> PASS' $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)

//--- dv/masterTb.sv
`timescale 1ns/1ps

module masterTb;
    import masterPkg::*;

    localparam int                    DATA_WIDTH     = 8;
    localparam logic [2:0]            SLAVE_ID       = 3'b101;
    localparam logic [DATA_WIDTH-1:0] START_DATA     = 8'd10;
    localparam logic [DATA_WIDTH-1:0] ACK_WORD       = 8'hCC;
    localparam int                    DISPLAY_CYCLES = 10;
    localparam int                    WAIT_LIMIT     = 400;   // cycles per wait
    localparam logic [2:0]            ACK_PATTERN    = 3'b101;

    typedef enum {cntStop, cntDisplay} counterT;

    logic                  clk = 1'b0;
    logic                  rstN;
    logic                  start;
    logic                  eoc;
    logic                  rD;
    logic                  ready;
    logic                  arbCont;
    doneCodeT              doneCom;
    logic [DATA_WIDTH-1:0] dataOut;
    logic                  disData;
    logic                  control;
    logic                  wrD;
    logic                  valid;
    logic                  arbSend;

    logic [DATA_WIDTH-1:0] replyAck;
    logic [DATA_WIDTH-1:0] replyData;
    logic [DATA_WIDTH-1:0] shownByte;   // byte expected on dataOut during display
    logic [DATA_WIDTH-1:0] nextData;
    logic [DATA_WIDTH+1:0] expNext;     // {done code, byte}
    int                    dispRun    = 0;
    int                    lastRun    = 0;
    int                    runCount   = 0;
    int                    errorCount = 0;
    int                    seedVal;

    always #4 clk = ~clk;

    masterExternal #(
        .DATA_WIDTH    (DATA_WIDTH),
        .SLAVE_ID      (SLAVE_ID),
        .START_DATA    (START_DATA),
        .ACK_WORD      (ACK_WORD),
        .DISPLAY_CYCLES(DISPLAY_CYCLES)
    ) masterExternal_i (
        .clk(clk), .rstN(rstN), .start(start), .eoc(eoc),
        .rD(rD), .ready(ready), .arbCont(arbCont),
        .doneCom(doneCom), .dataOut(dataOut), .disData(disData),
        .control(control), .wrD(wrD), .valid(valid), .arbSend(arbSend)
    );

    busModel #(.DATA_WIDTH(DATA_WIDTH)) slaveBus (
        .clk(clk), .rstN(rstN), .arbSend(arbSend), .control(control),
        .wrD(wrD), .valid(valid), .replyAck(replyAck), .replyData(replyData),
        .arbCont(arbCont), .rD(rD), .ready(ready)
    );

    ////////////////////
    // reference model
    ////////////////////
    function automatic arbReqT expRequest();
        arbReqT r;
        r.startMark = START_MARK;
        r.slaveId   = SLAVE_ID;
        return r;
    endfunction

    function automatic ctrlFrameT expFrame(input logic rw);
        ctrlFrameT f;
        f.startMark = START_MARK;
        f.slaveId   = SLAVE_ID;
        f.rw        = rw;
        return f;
    endfunction

    // good ack shows the data half next while a bad ack keeps the old byte
    function automatic logic [DATA_WIDTH+1:0] expNextDisplay(
        input logic [DATA_WIDTH-1:0] ackHalf,
        input logic [DATA_WIDTH-1:0] dataHalf
    );
        if (ackHalf == ACK_WORD) begin
            return {doneActive, dataHalf};
        end
        return {doneEnd, shownByte};
    endfunction

    task automatic checkEq(input string name, input logic [31:0] expVal,
                           input logic [31:0] actVal);
        if (expVal !== actVal) begin
            errorCount++;
            $display("** Error: %s expected %0h actual %0h", name, expVal, actVal);
            $display(">>> FAIL");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic timeoutFail(input string what);
        $display("Timeout: no %s within %0d cycles", what, WAIT_LIMIT);
        $display(">>> FAIL");
        $fatal(1, "wait timed out");
    endtask

    function automatic int counterValue(input counterT which);
        if (which == cntStop) begin
            return slaveBus.stopCount;
        end
        return runCount;
    endfunction

    task automatic waitCount(input counterT which, input int target, input string what);
        int waited;
        waited = 0;
        while (counterValue(which) < target) begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) timeoutFail(what);
        end
    endtask

    task automatic waitDone(input doneCodeT code, input string what);
        int waited;
        waited = 0;
        while (doneCom !== code) begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) timeoutFail(what);
        end
    endtask

    task automatic waitDisplay();
        int waited;
        waited = 0;
        while (!disData) begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) timeoutFail("display start");
        end
    endtask

    // watches the byte on every display cycle and the length of each run
    always @(posedge clk) begin
        if (disData) begin
            checkEq("display byte", shownByte, dataOut);
            dispRun <= dispRun + 1;
        end else if (dispRun != 0) begin
            lastRun  <= dispRun;
            runCount <= runCount + 1;
            dispRun  <= 0;
        end
    end

    ////////////////////
    // scenarios
    ////////////////////
    initial begin
        seedVal = $urandom(32'h17f6);
        rstN      <= 1'b0;
        start     <= 1'b1;   // idle goes straight to display
        eoc       <= 1'b0;
        replyAck  <= ACK_WORD;
        replyData <= '0;
        shownByte <= START_DATA;
        repeat (8) @(posedge clk);
        checkEq("reset outputs", 0, {control, wrD, valid, arbSend, disData});
        checkEq("reset doneCom", doneIdle, doneCom);
        rstN <= 1'b1;

        waitCount(cntDisplay, 1, "first display");
        checkEq("display length", DISPLAY_CYCLES, lastRun);
        start <= 1'b0;

        // write of the start byte
        waitCount(cntStop, 1, "write stop marker");
        checkEq("write request", expRequest(), slaveBus.reqWord);
        checkEq("write ack pattern", ACK_PATTERN, slaveBus.ackWord);
        checkEq("write frame", expFrame(1'b1), slaveBus.frameWord);
        checkEq("write data", shownByte, slaveBus.wrWord);
        checkEq("write bit count", DATA_WIDTH, slaveBus.wrBits);
        checkEq("stop length", 1, slaveBus.stopLen);
        checkEq("frame before grant", 0, slaveBus.earlyFrame);

        // read with good ack and random data
        nextData = DATA_WIDTH'($urandom);
        expNext  = expNextDisplay(ACK_WORD, nextData);
        replyAck  <= ACK_WORD;
        replyData <= nextData;
        shownByte <= expNext[DATA_WIDTH-1:0];
        waitCount(cntStop, 2, "read stop marker");
        checkEq("read request", expRequest(), slaveBus.reqWord);
        checkEq("read ack pattern", ACK_PATTERN, slaveBus.ackWord);
        checkEq("read frame", expFrame(1'b0), slaveBus.frameWord);
        checkEq("frame before grant", 0, slaveBus.earlyFrame);
        waitCount(cntDisplay, 2, "display of read data");
        checkEq("second display length", DISPLAY_CYCLES, lastRun);
        checkEq("done after good read", expNext[DATA_WIDTH+1 -: 2], doneCom);
        waitCount(cntStop, 3, "write back stop marker");
        checkEq("write back frame", expFrame(1'b1), slaveBus.frameWord);
        checkEq("write back data", nextData, slaveBus.wrWord);
        checkEq("write back stop", 1, slaveBus.stopLen);

        // read with a wrong ack
        expNext = expNextDisplay(~ACK_WORD, nextData);
        replyAck <= ~ACK_WORD;
        waitDone(doneCodeT'(expNext[DATA_WIDTH+1 -: 2]), "end after bad ack");
        checkEq("byte after bad ack", expNext[DATA_WIDTH-1:0], dataOut);
        repeat (50) @(posedge clk);
        checkEq("requests after bad ack", 4, slaveBus.reqCount);
        checkEq("arbSend after end", 0, arbSend);

        // eoc in the middle of a display
        rstN      <= 1'b0;
        start     <= 1'b1;
        replyAck  <= ACK_WORD;
        shownByte <= START_DATA;
        repeat (8) @(posedge clk);
        rstN <= 1'b1;
        waitDisplay();
        repeat (1 + $urandom % 5) @(posedge clk);
        eoc <= 1'b1;
        waitDone(doneEnd, "end after eoc");
        checkEq("byte held after eoc", START_DATA, dataOut);
        checkEq("disData after eoc", 0, disData);

        if (errorCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- dv/busModel.sv
`timescale 1ns/1ps

module busModel #(
    parameter int DATA_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  arbSend,
    input  logic                  control,
    input  logic                  wrD,
    input  logic                  valid,
    input  logic [DATA_WIDTH-1:0] replyAck,
    input  logic [DATA_WIDTH-1:0] replyData,
    output logic                  arbCont,
    output logic                  rD,
    output logic                  ready
);
    import masterPkg::*;

    typedef enum logic [3:0] {
        mIdle,
        mReq,
        mGrant,
        mAck,
        mFrame,
        mWrite,
        mRead,
        mStop,
        mRel,
        mRelEnd
    } modelStateT;

    modelStateT              state;
    logic                    contReg;
    logic                    rdReg;
    logic                    readyReg;
    logic [REQ_LEN-1:0]      reqSh;
    logic [CTRL_LEN-1:0]     frameSh;
    logic [DATA_WIDTH-1:0]   wrSh;
    logic [2*DATA_WIDTH-1:0] replySh;   // ack on top, data below
    int                      bitCnt;
    int                      delay;
    int                      taken;

    // decoded words and counters read by the testbench
    logic [REQ_LEN-1:0]    reqWord;
    logic [2:0]            ackWord;      // grant acknowledge seen on arbSend
    logic [CTRL_LEN-1:0]   frameWord;
    logic [DATA_WIDTH-1:0] wrWord;
    int                    reqCount;
    int                    wrBits;
    int                    stopCount;
    int                    stopLen;
    int                    earlyFrame;   // control seen before the grant

    assign arbCont = rstN & contReg;
    assign rD      = rstN & rdReg;
    assign ready   = rstN & readyReg;

    always @(posedge clk or negedge rstN) begin : modelFsm
        int                      nextTaken;
        logic [2*DATA_WIDTH-1:0] nextSh;
        if (!rstN) begin
            state      <= mIdle;
            contReg    <= 1'b0;
            rdReg      <= 1'b0;
            readyReg   <= 1'b0;
            bitCnt     <= 0;
            reqCount   <= 0;
            stopCount  <= 0;
            earlyFrame <= 0;
        end else begin
            if (control && (state inside {mIdle, mReq, mGrant, mAck})) begin
                earlyFrame <= earlyFrame + 1;
            end
            case (state)
                mIdle: begin
                    contReg  <= 1'b0;
                    readyReg <= 1'b0;
                    if (arbSend) begin   // first request bit is a start mark
                        reqSh  <= {reqSh[REQ_LEN-2:0], arbSend};
                        bitCnt <= 1;
                        state  <= mReq;
                    end
                end
                mReq: begin
                    reqSh  <= {reqSh[REQ_LEN-2:0], arbSend};
                    bitCnt <= bitCnt + 1;
                    if (bitCnt == REQ_LEN - 1) begin
                        reqWord  <= {reqSh[REQ_LEN-2:0], arbSend};
                        reqCount <= reqCount + 1;
                        delay    <= ($urandom % 2 == 0) ? 2 : int'($urandom % 7);
                        state    <= mGrant;
                    end
                end
                mGrant: begin
                    if (delay == 0) begin
                        contReg <= 1'b1;
                        state   <= mAck;
                    end else begin
                        delay <= delay - 1;
                    end
                end
                mAck: begin
                    if (arbSend) begin   // ack pattern has started
                        contReg <= 1'b0;
                        ackWord <= {2'b00, arbSend};
                        delay   <= 2;    // two more ack bits
                        bitCnt  <= 0;
                        state   <= mFrame;
                    end
                end
                ////////////////////
                // frame and data
                ////////////////////
                mFrame: begin
                    if (delay != 0) begin
                        ackWord <= {ackWord[1:0], arbSend};
                        delay   <= delay - 1;
                    end
                    if (control || bitCnt != 0) begin
                        frameSh <= {frameSh[CTRL_LEN-2:0], control};
                        bitCnt  <= bitCnt + 1;
                        if (bitCnt == CTRL_LEN - 1) begin
                            frameWord <= {frameSh[CTRL_LEN-2:0], control};
                            wrBits    <= 0;
                            taken     <= 0;
                            replySh   <= {replyAck, replyData};
                            state     <= control ? mWrite : mRead;   // last bit is rw
                        end
                    end
                end
                mWrite: begin
                    if (valid) begin
                        wrSh   <= {wrSh[DATA_WIDTH-2:0], wrD};
                        wrBits <= wrBits + 1;
                    end else if (wrBits != 0) begin
                        wrWord  <= wrSh;
                        stopLen <= control ? 1 : 0;   // stop follows the last bit
                        state   <= mStop;
                    end
                end
                mRead: begin
                    nextTaken = readyReg ? taken + 1 : taken;
                    nextSh    = readyReg ? {replySh[2*DATA_WIDTH-2:0], 1'b0} : replySh;
                    taken    <= nextTaken;
                    replySh  <= nextSh;
                    rdReg    <= nextSh[2*DATA_WIDTH-1];
                    readyReg <= ($urandom % 3 != 0);   // random gaps
                    if (nextTaken == 2 * DATA_WIDTH) begin
                        readyReg <= 1'b0;
                        stopLen  <= 0;
                        state    <= mStop;
                    end
                end
                mStop: begin
                    if (control) begin
                        stopLen <= stopLen + 1;
                    end else if (stopLen != 0) begin
                        stopCount <= stopCount + 1;
                        state     <= mRel;
                    end
                end
                mRel:    if (arbSend) state <= mRelEnd;
                mRelEnd: if (!arbSend) state <= mIdle;
                default: state <= mIdle;
            endcase
        end
    end

endmodule

//--- rtl/masterExternal.sv
`timescale 1ns/1ps

module masterExternal #(
    parameter int                    DATA_WIDTH     = 8,
    parameter logic [2:0]            SLAVE_ID       = 3'b101,
    parameter logic [DATA_WIDTH-1:0] START_DATA     = 8'd10,
    parameter logic [DATA_WIDTH-1:0] ACK_WORD       = 8'hCC,
    parameter int                    DISPLAY_CYCLES = 10
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  start,
    input  logic                  eoc,
    input  logic                  rD,
    input  logic                  ready,
    input  logic                  arbCont,
    output masterPkg::doneCodeT   doneCom,
    output logic [DATA_WIDTH-1:0] dataOut,
    output logic                  disData,
    output logic                  control,
    output logic                  wrD,
    output logic                  valid,
    output logic                  arbSend
);
    import masterPkg::*;

    ////////////////////
    // internal strobes
    ////////////////////
    logic                  reqStart, relStart, granted, released;
    logic                  frameLoad, frameBit, frameDone;
    logic                  dataLoad, dataDone;
    logic                  readEn, readDone, ackOk;
    logic [DATA_WIDTH-1:0] readData, dataWord;
    arbReqT                reqWord;
    ctrlFrameT             frame;

    masterSequencer #(
        .DATA_WIDTH    (DATA_WIDTH),
        .SLAVE_ID      (SLAVE_ID),
        .START_DATA    (START_DATA),
        .DISPLAY_CYCLES(DISPLAY_CYCLES)
    ) sequencer (
        .clk(clk), .rstN(rstN), .start(start), .eoc(eoc),
        .granted(granted), .released(released),
        .frameDone(frameDone), .dataDone(dataDone), .frameBit(frameBit),
        .readDone(readDone), .ackOk(ackOk), .readData(readData),
        .reqStart(reqStart), .relStart(relStart), .frameLoad(frameLoad),
        .dataLoad(dataLoad), .readEn(readEn), .reqWord(reqWord), .frame(frame),
        .dataWord(dataWord), .dataOut(dataOut), .disData(disData),
        .control(control), .doneCom(doneCom)
    );

    arbiterRequester requester (
        .clk(clk), .rstN(rstN), .reqStart(reqStart), .relStart(relStart),
        .arbCont(arbCont), .reqWord(reqWord),
        .arbSend(arbSend), .granted(granted), .released(released)
    );

    serialShifter #(.payloadT(ctrlFrameT)) frameShift (
        .clk(clk), .rstN(rstN), .load(frameLoad), .payload(frame),
        .bitOut(frameBit), .busy(), .done(frameDone)
    );

    // write data goes straight to the slave pins
    serialShifter #(.payloadT(logic [DATA_WIDTH-1:0])) dataShift (
        .clk(clk), .rstN(rstN), .load(dataLoad), .payload(dataWord),
        .bitOut(wrD), .busy(valid), .done(dataDone)
    );

    readCollector #(
        .DATA_WIDTH(DATA_WIDTH),
        .ACK_WORD  (ACK_WORD)
    ) collector (
        .clk(clk), .rstN(rstN), .readEn(readEn), .rD(rD), .ready(ready),
        .readData(readData), .ackOk(ackOk), .readDone(readDone)
    );

endmodule

//--- rtl/masterSequencer.sv
`timescale 1ns/1ps

module masterSequencer #(
    parameter int                    DATA_WIDTH     = 8,
    parameter logic [2:0]            SLAVE_ID       = 3'b101,
    parameter logic [DATA_WIDTH-1:0] START_DATA     = 8'd10,
    parameter int                    DISPLAY_CYCLES = 10
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   start,
    input  logic                   eoc,
    input  logic                   granted,
    input  logic                   released,
    input  logic                   frameDone,
    input  logic                   dataDone,
    input  logic                   frameBit,
    input  logic                   readDone,
    input  logic                   ackOk,
    input  logic [DATA_WIDTH-1:0]  readData,
    output logic                   reqStart,
    output logic                   relStart,
    output logic                   frameLoad,
    output logic                   dataLoad,
    output logic                   readEn,
    output masterPkg::arbReqT      reqWord,
    output masterPkg::ctrlFrameT   frame,
    output logic [DATA_WIDTH-1:0]  dataWord,
    output logic [DATA_WIDTH-1:0]  dataOut,
    output logic                   disData,
    output logic                   control,
    output masterPkg::doneCodeT    doneCom
);
    import masterPkg::*;

    localparam int                DCNT_W    = (DISPLAY_CYCLES > 1) ? $clog2(DISPLAY_CYCLES) : 1;
    localparam logic [DCNT_W-1:0] DISP_LAST = DCNT_W'(DISPLAY_CYCLES - 1);

    masterStateT           state;
    comPhaseT              phase;
    logic [DATA_WIDTH-1:0] dataReg;    // byte shown and written back
    logic [DCNT_W-1:0]     dispCnt;
    logic                  stopMark;   // one-cycle stop on control
    logic                  isWrite;

    assign isWrite  = (state == stWrite);
    assign reqWord  = '{startMark: START_MARK, slaveId: SLAVE_ID};
    assign frame    = '{startMark: START_MARK, slaveId: SLAVE_ID, rw: isWrite};
    assign dataWord = dataReg;
    assign dataOut  = dataReg;
    assign disData  = (state == stDisplay);
    assign control  = frameBit | stopMark;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= stIdle;
            phase     <= phRequest;
            dataReg   <= '0;
            dispCnt   <= '0;
            stopMark  <= 1'b0;
            doneCom   <= doneIdle;
            reqStart  <= 1'b0;
            relStart  <= 1'b0;
            frameLoad <= 1'b0;
            dataLoad  <= 1'b0;
            readEn    <= 1'b0;
        end else begin
            reqStart  <= 1'b0;   // strobes default low
            relStart  <= 1'b0;
            frameLoad <= 1'b0;
            dataLoad  <= 1'b0;
            stopMark  <= 1'b0;
            if (eoc && (state inside {stDisplay, stWrite, stRead})) begin
                state   <= stEnd;
                doneCom <= doneEnd;
                readEn  <= 1'b0;
            end else begin
                case (state)
                    stIdle: begin
                        dispCnt <= '0;
                        phase   <= phRequest;
                        if (start && !eoc) begin
                            dataReg <= START_DATA;
                            state   <= stDisplay;
                        end else if (eoc) begin
                            doneCom <= doneEnd;
                            state   <= stEnd;
                        end else begin
                            reqStart <= 1'b1;   // wait for a reply from the far side
                            state    <= stRead;
                        end
                    end
                    stDisplay: begin
                        if (dispCnt == DISP_LAST) begin
                            reqStart <= 1'b1;
                            phase    <= phRequest;
                            state    <= stWrite;
                        end else begin
                            dispCnt <= dispCnt + 1'b1;
                        end
                    end
                    ////////////////////
                    // one transfer
                    ////////////////////
                    stWrite, stRead: begin
                        case (phase)
                            phRequest: begin
                                if (granted) begin
                                    frameLoad <= 1'b1;
                                    phase     <= phFrame;
                                end
                            end
                            phFrame: begin
                                if (frameDone) begin
                                    dataLoad <= isWrite;
                                    readEn   <= !isWrite;
                                    phase    <= phData;
                                end
                            end
                            phData: begin
                                if (isWrite ? dataDone : readDone) begin
                                    readEn   <= 1'b0;
                                    stopMark <= 1'b1;
                                    phase    <= phStop;
                                end
                            end
                            phStop: begin
                                relStart <= 1'b1;
                                phase    <= phRelease;
                            end
                            phRelease: begin
                                if (released && isWrite) begin
                                    reqStart <= 1'b1;   // straight into the read
                                    phase    <= phRequest;
                                    state    <= stRead;
                                end else if (released) begin
                                    phase <= phCheck;
                                end
                            end
                            phCheck: begin
                                phase <= phRequest;
                                if (ackOk) begin
                                    dataReg <= readData;
                                    doneCom <= doneActive;
                                    dispCnt <= '0;
                                    state   <= stDisplay;
                                end else begin
                                    doneCom <= doneEnd;   // bad ack closes the link
                                    state   <= stEnd;
                                end
                            end
                            default: phase <= phRequest;
                        endcase
                    end
                    stEnd:   doneCom <= doneEnd;
                    default: state <= stIdle;
                endcase
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) !(reqStart && relStart));

endmodule

//--- rtl/readCollector.sv
`timescale 1ns/1ps

module readCollector #(
    parameter int                    DATA_WIDTH = 8,
    parameter logic [DATA_WIDTH-1:0] ACK_WORD   = 8'hCC
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  readEn,
    input  logic                  rD,
    input  logic                  ready,
    output logic [DATA_WIDTH-1:0] readData,
    output logic                  ackOk,
    output logic                  readDone
);

    localparam int TOTAL = 2 * DATA_WIDTH;
    localparam int CNT_W = $clog2(TOTAL + 1);

    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(TOTAL);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(TOTAL - 1);

    logic [TOTAL-1:0] rxReg;      // ack word on top, data below
    logic [CNT_W-1:0] sampleCnt;
    logic             takeBit;

    assign takeBit  = readEn && ready && !readDone;
    assign ackOk    = (rxReg[TOTAL-1 -: DATA_WIDTH] == ACK_WORD);
    assign readData = rxReg[DATA_WIDTH-1:0];

    ////////////////////
    // sample path
    ////////////////////
    always_ff @(posedge clk) begin
        if (takeBit) begin
            rxReg <= {rxReg[TOTAL-2:0], rD};   // MSB arrives first
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            sampleCnt <= '0;
            readDone  <= 1'b0;
        end else begin
            readDone <= takeBit && (sampleCnt == LAST_CNT);
            if (!readEn) begin
                sampleCnt <= '0;   // ready for the next read
            end else if (takeBit) begin
                sampleCnt <= sampleCnt + 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) sampleCnt <= FULL_CNT);

endmodule

//--- rtl/serialShifter.sv
`timescale 1ns/1ps

module serialShifter #(
    parameter type payloadT = logic [7:0]
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    load,
    input  payloadT payload,
    output logic    bitOut,
    output logic    busy,
    output logic    done
);

    localparam int WIDTH = $bits(payloadT);
    localparam int CNT_W = $clog2(WIDTH + 1);

    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(WIDTH);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(1);

    logic [WIDTH-1:0] shiftReg;   // MSB is on the line
    logic [CNT_W-1:0] bitsLeft;

    assign busy   = (bitsLeft != '0);
    assign done   = (bitsLeft == LAST_CNT);   // last bit on the line
    assign bitOut = busy & shiftReg[WIDTH-1];

    ////////////////////
    // shift data path
    ////////////////////
    always_ff @(posedge clk) begin
        if (load) begin
            shiftReg <= payload;
        end else if (busy) begin
            shiftReg <= {shiftReg[WIDTH-2:0], 1'b0};
        end
    end

    // bit counter
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bitsLeft <= '0;
        end else if (load) begin
            bitsLeft <= FULL_CNT;
        end else if (busy) begin
            bitsLeft <= bitsLeft - 1'b1;
        end
    end

    // a new payload only once the previous one is fully out
    assert property (@(posedge clk) disable iff (!rstN) load |-> !busy);

endmodule

//--- rtl/arbiterRequester.sv
`timescale 1ns/1ps

module arbiterRequester (
    input  logic             clk,
    input  logic             rstN,
    input  logic             reqStart,
    input  logic             relStart,
    input  logic             arbCont,
    input  masterPkg::arbReqT reqWord,
    output logic             arbSend,
    output logic             granted,
    output logic             released
);
    import masterPkg::*;

    localparam int                BIT_W    = $clog2(REQ_LEN);
    localparam logic [BIT_W-1:0]  LAST_IDX = BIT_W'(REQ_LEN - 1);

    typedef enum logic [2:0] {
        aIdle,
        aReq,
        aWait,
        aAck,
        aRel
    } reqStateT;

    reqStateT           state;
    logic [REQ_LEN-1:0] reqSh;     // request bits still to go
    logic [BIT_W-1:0]   bitCnt;
    logic [1:0]         seqCnt;    // step inside ack / release pattern
    logic [1:0]         arbHist;   // two-flop grant history

    assign granted  = (state == aAck) && (seqCnt == 2'd2);
    assign released = (state == aRel) && (seqCnt == 2'd2);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= aIdle;
            reqSh   <= '0;
            bitCnt  <= '0;
            seqCnt  <= '0;
            arbHist <= '0;
            arbSend <= 1'b0;
        end else begin
            arbHist <= {arbHist[0], arbCont};
            case (state)
                aIdle: begin
                    arbSend <= 1'b0;
                    seqCnt  <= '0;
                    if (reqStart) begin
                        arbSend <= reqWord[REQ_LEN-1];   // first bit next cycle
                        reqSh   <= {reqWord[REQ_LEN-2:0], 1'b0};
                        bitCnt  <= LAST_IDX;
                        state   <= aReq;
                    end else if (relStart) begin
                        arbSend <= 1'b1;
                        state   <= aRel;
                    end
                end
                aReq: begin
                    if (bitCnt != '0) begin
                        arbSend <= reqSh[REQ_LEN-1];
                        reqSh   <= {reqSh[REQ_LEN-2:0], 1'b0};
                        bitCnt  <= bitCnt - 1'b1;
                    end else begin
                        arbSend <= 1'b0;
                        state   <= aWait;
                    end
                end
                aWait: begin
                    if (arbHist == 2'b11) begin
                        arbSend <= 1'b1;   // ack pattern 1,0,1
                        seqCnt  <= '0;
                        state   <= aAck;
                    end
                end
                aAck: begin
                    seqCnt  <= seqCnt + 1'b1;
                    arbSend <= (seqCnt == 2'd1);   // low, then high in the last step
                    if (seqCnt == 2'd2) begin
                        arbSend <= 1'b0;
                        state   <= aIdle;
                    end
                end
                aRel: begin
                    seqCnt  <= seqCnt + 1'b1;
                    arbSend <= 1'b0;
                    if (seqCnt == 2'd0) arbSend <= 1'b1;   // second high cycle
                    if (seqCnt == 2'd2) state <= aIdle;
                end
                default: state <= aIdle;
            endcase
        end
    end

    // bus line stays quiet between sequences
    assert property (@(posedge clk) disable iff (!rstN) (state == aIdle) |-> !arbSend);

endmodule

//--- rtl/masterPkg.sv
package masterPkg;

    ////////////////////
    // link constants
    ////////////////////
    localparam int         REQ_LEN    = 6;       // bits shifted onto arbSend per request
    localparam int         CTRL_LEN   = 7;       // control frame length on control
    localparam logic [2:0] START_MARK = 3'b111;  // leads request word and control frame

    ////////////////////
    // frame layouts
    ////////////////////
    // request word, MSB first on arbSend
    typedef struct packed {
        logic [2:0] startMark;
        logic [2:0] slaveId;
    } arbReqT;

    // control frame, MSB first on control
    typedef struct packed {
        logic [2:0] startMark;
        logic [2:0] slaveId;
        logic       rw;         // 1 write, 0 read
    } ctrlFrameT;

    // status towards the top side
    typedef enum logic [1:0] {
        doneIdle   = 2'b00,
        doneEnd    = 2'b01,
        doneActive = 2'b11
    } doneCodeT;

    ////////////////////
    // sequencer states
    ////////////////////
    typedef enum logic [2:0] {
        stIdle,
        stDisplay,
        stWrite,
        stRead,
        stEnd
    } masterStateT;

    // steps inside one write or read
    typedef enum logic [2:0] {
        phRequest,
        phFrame,
        phData,
        phStop,
        phRelease,
        phCheck
    } comPhaseT;

endpackage
